//--- sources.f
common/membuf_pkg.sv
fifo/fifo_same_clock.sv
design/cmd_ingress.sv
design/mem_sequencer.sv
design/resp_egress.sv
design/membuf_top.sv
tb/membuf_tb.sv

//--- tb/membuf_tb.sv
// testbench for the memory buffer
// sender and receiver models, reference memory, checks, watchdog

`timescale 1ns/1ps
`default_nettype none

module membuf_tb;

  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 6;
  localparam int FIFO_DEPTH   = 4;
  localparam int CMD_CREDITS  = 8;
  localparam int RESP_CREDITS = 4;
  localparam int CLK_PERIOD   = 40;
  localparam int BP_CMDS      = 24;  // reads sent while receiver withholds
  localparam int RAND_CMDS    = 300;
  localparam int HOLD_CYCLES  = 100; // length of a withhold phase
  localparam int CMD_CYCLES   = 40;  // worst case per command
  localparam int NUM_CMDS     = 22 + BP_CMDS + RAND_CMDS + 40;
  localparam int LIMIT_CYCLES = NUM_CMDS * CMD_CYCLES + 4 * HOLD_CYCLES + 16;
  localparam logic [ADDR_WIDTH-1:0] OVR_ADDR = 6'd9;

  logic                  clk;
  logic                  rst;
  logic                  cmd_valid;
  membuf_pkg::op_e       cmd_op;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic                  cmd_credit;
  logic                  cmd_overrun;
  logic                  resp_valid;
  logic [DATA_WIDTH-1:0] resp_data;
  logic                  resp_credit = 1'b0;

  logic [DATA_WIDTH-1:0] ref_mem [0:(1<<ADDR_WIDTH)-1]; // reference memory
  logic [DATA_WIDTH-1:0] exp_q [$];                     // expected responses
  logic [DATA_WIDTH-1:0] exp_word;
  int                    sent = 0;       // commands accepted by the sender model
  int                    cred_back = 0;  // cmd_credit pulses seen
  int                    pending = 0;    // credits the receiver still owes
  int                    resp_seen = 0;
  int                    cred_given = 0;
  int                    errors = 0;
  int                    checked = 0;
  int unsigned           seed = 32'h24aa;
  logic                  withhold = 1'b0; // receiver holds its credits
  logic                  ovr_expected = 1'b0;
  logic                  give;
  string                 test_name = "reset";

  membuf_top #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .CMD_CREDITS (CMD_CREDITS),
    .RESP_CREDITS(RESP_CREDITS)
  ) uut (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_addr(cmd_addr), .cmd_data(cmd_data), .cmd_credit(cmd_credit),
    .cmd_overrun(cmd_overrun), .resp_valid(resp_valid), .resp_data(resp_data),
    .resp_credit(resp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // credits the sender holds now including a pulse this cycle
  function automatic int credits_left();
    return CMD_CREDITS - sent + cred_back + int'(cmd_credit);
  endfunction

  // count returned credits against commands sent
  always @(negedge clk) begin
    if (!rst && cmd_credit) begin
      assert (cred_back < sent) else begin
        errors++;
        $display("credit pulse with no command outstanding in %s", test_name);
      end
      cred_back <= cred_back + 1;
    end
  end

  // receiver model comparing each response and returning credits
  always @(negedge clk) begin
    if (rst) begin
      resp_credit <= 1'b0;
    end else begin
      give = !withhold && (pending + int'(resp_valid) > 0) && ($urandom_range(3) != 0);
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response %h arrived with none expected in %s", resp_data, test_name);
        end else begin
          exp_word = exp_q.pop_front();
          checked++;
          assert (resp_data == exp_word) else begin
            errors++;
            $display("** Error [%s] response expected %h actual %h",
                     test_name, exp_word, resp_data);
          end
        end
      end
      assert (resp_seen + int'(resp_valid) - cred_given <= RESP_CREDITS) else begin
        errors++;
        $display("responses exceed receiver credits in %s", test_name);
      end
      pending     <= pending + int'(resp_valid) - int'(give);
      resp_seen   <= resp_seen + int'(resp_valid);
      cred_given  <= cred_given + int'(give);
      resp_credit <= give;
    end
  end

  // overrun flag low until the deliberate drop and high after it
  always @(negedge clk) begin
    if (!rst) begin
      assert (cmd_overrun == ovr_expected) else begin
        errors++;
        $display("** Error [%s] cmd_overrun expected %b actual %b",
                 test_name, ovr_expected, cmd_overrun);
      end
    end
  end

  // send one command once a credit is held and update the reference model
  task automatic send_cmd(input membuf_pkg::op_e op, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data);
    while (credits_left() == 0) begin
      cmd_valid = 1'b0;
      @(negedge clk);
    end
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_data  = data;
    sent     <= sent + 1;
    case (op)
      membuf_pkg::OP_WRITE: ref_mem[addr] = data;
      membuf_pkg::OP_READ:  exp_q.push_back(ref_mem[addr]);
      default: begin
        ref_mem[addr] = ref_mem[addr] + data; // wraps at 2**32
        exp_q.push_back(ref_mem[addr]);
      end
    endcase
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // all responses in and all credits back
  task automatic wait_idle();
    @(negedge clk);
    while (exp_q.size() != 0 || sent != cred_back || pending != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    assert (cred_back == sent) else begin
      errors++;
      $display("** Error [%s] credit pulses expected %0d actual %0d",
               test_name, sent, cred_back);
    end
  endtask

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("watchdog: no finish after %0d cycles, DUT hung in %s", LIMIT_CYCLES, test_name);
    $display("checks done: %0d errors, %0d responses compared", errors, checked);
    $display("Regression failed");
    $finish;
  end

  initial begin
    int start_seen;
    int stall;
    void'($urandom(seed));
    for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
      ref_mem[i] = '0;                        // memory starts at zero
    end
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = membuf_pkg::OP_WRITE;
    cmd_addr  = '0;
    cmd_data  = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    assert (!cmd_credit && !resp_valid) else begin
      errors++;
      $display("outputs not idle after reset");
    end

    test_name = "write_read";
    for (int i = 0; i < 8; i++) begin
      send_cmd(membuf_pkg::OP_WRITE, 6'(i * 7), 32'hc0de_0000 + 32'(i * 32'h1111));
    end
    for (int i = 0; i < 8; i++) begin
      send_cmd(membuf_pkg::OP_READ, 6'(i * 7), '0);
    end
    wait_idle();

    test_name = "accumulate";
    send_cmd(membuf_pkg::OP_WRITE, 6'd20, 32'hffff_fff0);
    send_cmd(membuf_pkg::OP_ACCUM, 6'd20, 32'h0000_0025); // wraps past zero
    send_cmd(membuf_pkg::OP_ACCUM, 6'd33, 32'h1234_5678); // untouched word
    send_cmd(membuf_pkg::OP_READ, 6'd20, '0);
    send_cmd(membuf_pkg::OP_READ, 6'd33, '0);
    send_cmd(membuf_pkg::OP_ACCUM, 6'd33, 32'h0000_0001);
    wait_idle();

    test_name  = "back_pressure";
    withhold  <= 1'b1;
    start_seen = resp_seen;
    for (int i = 0; i < BP_CMDS; i++) begin
      send_cmd(membuf_pkg::OP_READ, 6'(i), '0);
    end
    repeat (HOLD_CYCLES) @(negedge clk);
    assert (resp_seen - start_seen <= RESP_CREDITS) else begin
      errors++;
      $display("** Error [%s] responses while held expected <= %0d actual %0d",
               test_name, RESP_CREDITS, resp_seen - start_seen);
    end
    withhold <= 1'b0;
    wait_idle();

    test_name = "random";
    for (int i = 0; i < RAND_CMDS; i++) begin
      send_cmd(membuf_pkg::op_e'($urandom_range(2)), 6'($urandom), $urandom);
      repeat ($urandom_range(2)) @(negedge clk);
    end
    wait_idle();

    // fill the pipeline until the sender runs dry
    test_name = "overrun";
    withhold <= 1'b1;
    stall     = 0;
    while (stall < 20) begin
      if (credits_left() > 0) begin
        send_cmd(membuf_pkg::OP_READ, 6'($urandom), '0);
        stall = 0;
      end else begin
        @(negedge clk);
        stall++;
      end
    end
    assert (credits_left() == 0) else begin
      errors++;
      $display("sender still held credits before the overrun command");
    end
    cmd_valid     = 1'b1;                     // sent with no credit so it is dropped
    cmd_op        = membuf_pkg::OP_WRITE;
    cmd_addr      = OVR_ADDR;
    cmd_data      = 32'hdead_beef;
    ovr_expected <= 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    withhold <= 1'b0;
    wait_idle();
    send_cmd(membuf_pkg::OP_READ, OVR_ADDR, '0); // word must be unchanged
    wait_idle();

    $display("checks done: %0d errors, %0d responses compared", errors, checked);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/membuf_top.sv
// memory buffer top level
// ingress, sequencer and egress instances with their parameters

`timescale 1ns/1ps
`default_nettype none

module membuf_top #(
  parameter int DATA_WIDTH   = 32,
  parameter int ADDR_WIDTH   = 6,
  parameter int FIFO_DEPTH   = 4,
  parameter int CMD_CREDITS  = 8, // at most 2**FIFO_DEPTH
  parameter int RESP_CREDITS = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  cmd_valid,
  input  wire membuf_pkg::op_e       cmd_op,
  input  wire logic [ADDR_WIDTH-1:0] cmd_addr,
  input  wire logic [DATA_WIDTH-1:0] cmd_data,
  output logic                       cmd_credit,
  output logic                       cmd_overrun,
  output logic                       resp_valid,
  output logic      [DATA_WIDTH-1:0] resp_data,
  input  wire logic                  resp_credit
);

  logic                  cmd_ready; // ingress head valid
  logic                  cmd_pop;
  membuf_pkg::op_e       q_op;
  logic [ADDR_WIDTH-1:0] q_addr;
  logic [DATA_WIDTH-1:0] q_data;
  logic                  rsp_push;  // sequencer result
  logic [DATA_WIDTH-1:0] rsp_word;
  logic                  rsp_taken; // egress slot freed

  cmd_ingress #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH),
    .CMD_CREDITS(CMD_CREDITS)
  ) u_ingress (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),
    .cmd_data   (cmd_data),
    .cmd_credit (cmd_credit),
    .cmd_overrun(cmd_overrun),
    .cmd_ready  (cmd_ready),
    .cmd_pop    (cmd_pop),
    .q_op       (q_op),
    .q_addr     (q_addr),
    .q_data     (q_data)
  );

  mem_sequencer #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_sequencer (
    .clk      (clk),
    .rst      (rst),
    .cmd_ready(cmd_ready),
    .q_op     (q_op),
    .q_addr   (q_addr),
    .q_data   (q_data),
    .cmd_pop  (cmd_pop),
    .rsp_push (rsp_push),
    .rsp_word (rsp_word),
    .rsp_taken(rsp_taken)
  );

  resp_egress #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .RESP_CREDITS(RESP_CREDITS)
  ) u_egress (
    .clk        (clk),
    .rst        (rst),
    .rsp_push   (rsp_push),
    .rsp_word   (rsp_word),
    .rsp_taken  (rsp_taken),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_credit(resp_credit)
  );

endmodule

`default_nettype wire

//--- design/resp_egress.sv
// response output side
// response FIFO and receiver credit counter

`timescale 1ns/1ps
`default_nettype none

module resp_egress #(
  parameter int DATA_WIDTH   = 32,
  parameter int FIFO_DEPTH   = 4,
  parameter int RESP_CREDITS = 4
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  rsp_push,
  input  wire logic [DATA_WIDTH-1:0] rsp_word,
  output logic                       rsp_taken,   // word left the FIFO
  output logic                       resp_valid,
  output logic      [DATA_WIDTH-1:0] resp_data,
  input  wire logic                  resp_credit  // receiver returns one credit
);

  localparam int CRED_W = $clog2(RESP_CREDITS + 1);

  logic [CRED_W-1:0]     credits;   // credits held toward the receiver
  logic                  head_ok;   // FIFO head valid
  logic [DATA_WIDTH-1:0] head_word;
  logic                  issue;     // send head this cycle

  assign issue     = head_ok && (credits != '0);
  assign rsp_taken = issue;

  fifo_same_clock #(
    .DATA_WIDTH(DATA_WIDTH),
    .DATA_DEPTH(FIFO_DEPTH)
  ) rsp_fifo (
    .clk      (clk),
    .rst      (rst),
    .we       (rsp_push),
    .re       (issue),
    .data_in  (rsp_word),
    .data_out (head_word),
    .nempty   (head_ok),
    .half_full()
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits    <= CRED_W'(RESP_CREDITS);
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= issue;                  // one cycle per word
      if (issue && !resp_credit) begin
        credits <= credits - 1'b1;
      end else if (!issue && resp_credit) begin
        credits <= credits + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      resp_data <= head_word;               // held until next issue
    end
  end

endmodule

`default_nettype wire

//--- design/mem_sequencer.sv
// command sequencer
// word memory, egress slot counter, write/read/accumulate FSM

`timescale 1ns/1ps
`default_nettype none

module mem_sequencer #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 6,
  parameter int FIFO_DEPTH = 4 // egress FIFO RAM is 2**FIFO_DEPTH words
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  cmd_ready,
  input  wire membuf_pkg::op_e       q_op,
  input  wire logic [ADDR_WIDTH-1:0] q_addr,
  input  wire logic [DATA_WIDTH-1:0] q_data,
  output logic                       cmd_pop,
  output logic                       rsp_push,
  output logic      [DATA_WIDTH-1:0] rsp_word,
  input  wire logic                  rsp_taken  // egress slot freed
);

  localparam int MEM_WORDS = 1 << ADDR_WIDTH;
  localparam int SLOTS     = 1 << FIFO_DEPTH;

  logic [DATA_WIDTH-1:0]  mem [0:MEM_WORDS-1];
  membuf_pkg::seq_state_e state;
  logic [FIFO_DEPTH:0]    free_slots; // egress words not yet committed
  membuf_pkg::op_e        op_r;       // command in flight
  logic [ADDR_WIDTH-1:0]  addr_r;
  logic [DATA_WIDTH-1:0]  data_r;
  logic [DATA_WIDTH-1:0]  rd_data;    // memory read result
  logic [DATA_WIDTH-1:0]  sum;
  logic                   wr_en;
  logic [ADDR_WIDTH-1:0]  wr_addr;
  logic [DATA_WIDTH-1:0]  wr_data;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;                        // memory starts at zero
    end
  end

  // only reads and accumulates need a free slot
  assign cmd_pop = (state == membuf_pkg::SEQ_IDLE) && cmd_ready &&
                   ((q_op == membuf_pkg::OP_WRITE) || (free_slots != '0));

  assign sum      = rd_data + data_r;     // wraps modulo 2**DATA_WIDTH
  assign rsp_push = (state == membuf_pkg::SEQ_RESP);
  assign rsp_word = (op_r == membuf_pkg::OP_ACCUM) ? sum : rd_data;

  // single write port shared by plain write and accumulate write back
  assign wr_en   = (cmd_pop && (q_op == membuf_pkg::OP_WRITE)) ||
                   (state == membuf_pkg::SEQ_WBACK);
  assign wr_addr = (state == membuf_pkg::SEQ_WBACK) ? addr_r : q_addr;
  assign wr_data = (state == membuf_pkg::SEQ_WBACK) ? sum : q_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= membuf_pkg::SEQ_IDLE;
      free_slots <= (FIFO_DEPTH+1)'(SLOTS);
    end else begin
      if (rsp_push && !rsp_taken) begin
        free_slots <= free_slots - 1'b1;
      end else if (!rsp_push && rsp_taken) begin
        free_slots <= free_slots + 1'b1;
      end
      case (state)
        membuf_pkg::SEQ_IDLE: begin
          if (cmd_pop && (q_op != membuf_pkg::OP_WRITE)) begin
            state <= membuf_pkg::SEQ_READ;  // write already done
          end
        end
        membuf_pkg::SEQ_READ: begin
          state <= membuf_pkg::SEQ_RESP;
        end
        membuf_pkg::SEQ_RESP: begin
          if (op_r == membuf_pkg::OP_ACCUM) begin
            state <= membuf_pkg::SEQ_WBACK;
          end else begin
            state <= membuf_pkg::SEQ_IDLE;
          end
        end
        default: begin
          state <= membuf_pkg::SEQ_IDLE;    // write back ends here
        end
      endcase
    end
  end

  // command capture and word memory
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      op_r   <= q_op;
      addr_r <= q_addr;
      data_r <= q_data;
    end
    if (state == membuf_pkg::SEQ_READ) begin
      rd_data <= mem[addr_r];
    end
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- design/cmd_ingress.sv
// command input side
// sender credit tracking, overrun flag, command FIFO

`timescale 1ns/1ps
`default_nettype none

module cmd_ingress #(
  parameter int DATA_WIDTH  = 32,
  parameter int ADDR_WIDTH  = 6,
  parameter int FIFO_DEPTH  = 4,
  parameter int CMD_CREDITS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  cmd_valid,
  input  wire membuf_pkg::op_e       cmd_op,
  input  wire logic [ADDR_WIDTH-1:0] cmd_addr,
  input  wire logic [DATA_WIDTH-1:0] cmd_data,
  output logic                       cmd_credit,  // one credit back per pulse
  output logic                       cmd_overrun, // sticky until reset
  output logic                       cmd_ready,   // head command valid
  input  wire logic                  cmd_pop,
  output membuf_pkg::op_e            q_op,
  output logic      [ADDR_WIDTH-1:0] q_addr,
  output logic      [DATA_WIDTH-1:0] q_data
);

  localparam int WORD_W = membuf_pkg::OP_BITS + ADDR_WIDTH + DATA_WIDTH;
  localparam int CRED_W = $clog2(CMD_CREDITS + 1);

  logic [CRED_W-1:0] credits;  // credits the sender still holds
  logic              accept;   // command goes into the FIFO
  logic [WORD_W-1:0] head_word;

  // a credit returned this cycle may be spent at once
  assign accept = cmd_valid && ((credits != '0) || cmd_credit);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits     <= CRED_W'(CMD_CREDITS);
      cmd_credit  <= 1'b0;
      cmd_overrun <= 1'b0;
    end else begin
      cmd_credit <= cmd_pop;                     // credit follows the pop
      if (cmd_credit && !accept) begin
        credits <= credits + 1'b1;
      end else if (!cmd_credit && accept) begin
        credits <= credits - 1'b1;
      end
      if (cmd_valid && !accept) begin
        cmd_overrun <= 1'b1;                     // command dropped
      end
    end
  end

  fifo_same_clock #(
    .DATA_WIDTH(WORD_W),
    .DATA_DEPTH(FIFO_DEPTH)
  ) cmd_fifo (
    .clk      (clk),
    .rst      (rst),
    .we       (accept),
    .re       (cmd_pop),
    .data_in  ({cmd_op, cmd_addr, cmd_data}),
    .data_out (head_word),
    .nempty   (cmd_ready),
    .half_full()
  );

  // unpack head command with op in the top bits
  assign q_op   = membuf_pkg::op_e'(head_word[WORD_W-1 -: membuf_pkg::OP_BITS]);
  assign q_addr = head_word[DATA_WIDTH +: ADDR_WIDTH];
  assign q_data = head_word[DATA_WIDTH-1:0];

endmodule

`default_nettype wire

//--- fifo/fifo_same_clock.sv
// single clock FIFO
// input register, RAM, prefetching output register

`timescale 1ns/1ps
`default_nettype none

module fifo_same_clock #(
  parameter int DATA_WIDTH = 16,
  parameter int DATA_DEPTH = 4 // log2 of RAM words
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  we,        // write enable
  input  wire logic                  re,        // read enable, pops data_out
  input  wire logic [DATA_WIDTH-1:0] data_in,
  output logic      [DATA_WIDTH-1:0] data_out,  // head word, valid with nempty
  output logic                       nempty,    // output register holds data
  output logic                       half_full  // RAM at least half full
);

  localparam int RAM_WORDS = 1 << DATA_DEPTH;

  logic [DATA_WIDTH-1:0] ram [0:RAM_WORDS-1];
  logic [DATA_WIDTH-1:0] inreg;      // input stage
  logic [DATA_WIDTH-1:0] outreg;     // prefetched head
  logic [DATA_DEPTH:0]   fill;       // words in RAM, one extra bit for full
  logic [DATA_DEPTH:0]   next_fill;
  logic [DATA_DEPTH-1:0] wa;         // write pointer
  logic [DATA_DEPTH-1:0] ra;         // read pointer
  logic                  wem;        // delayed write enable, RAM write
  logic                  rem;        // RAM read into outreg
  logic                  ram_nempty; // RAM holds at least one word
  logic                  out_full;   // outreg valid

  // move a word to outreg when popped or when outreg is empty
  assign rem      = ram_nempty && (re || !out_full);
  assign data_out = outreg;
  assign nempty   = out_full;

  always_comb begin
    next_fill = fill;
    if (wem && !rem) begin
      next_fill = fill + 1'b1;
    end else if (!wem && rem) begin
      next_fill = fill - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill       <= '0;
      wem        <= 1'b0;
      ram_nempty <= 1'b0;
      wa         <= '0;
      ra         <= '0;
      out_full   <= 1'b0;
      half_full  <= 1'b0;
    end else begin
      fill       <= next_fill;
      wem        <= we;                            // inreg lands next cycle
      ram_nempty <= (next_fill != '0);
      half_full  <= (next_fill[DATA_DEPTH:DATA_DEPTH-1] != 2'b00);
      if (wem) begin
        wa <= wa + 1'b1;
      end
      if (rem) begin
        ra <= ra + 1'b1;
      end else if (!ram_nempty) begin
        ra <= wa;                                  // resync when drained
      end
      if (rem && !re) begin
        out_full <= 1'b1;
      end else if (re && !rem) begin
        out_full <= 1'b0;
      end
    end
  end

  // datapath, no reset
  always_ff @(posedge clk) begin
    if (we) begin
      inreg <= data_in;
    end
    if (wem) begin
      ram[wa] <= inreg;
    end
    if (rem) begin
      outreg <= ram[ra];
    end
  end

endmodule

`default_nettype wire

//--- common/membuf_pkg.sv
// shared definitions for the memory buffer
// command opcodes, opcode width, sequencer states

`default_nettype none

package membuf_pkg;

  localparam int OP_BITS = 2; // width of op_e

  // command opcodes as carried on the command port
  typedef enum logic [OP_BITS-1:0] {
    OP_WRITE = 2'd0, // store data at address
    OP_READ  = 2'd1, // return word at address
    OP_ACCUM = 2'd2  // add data to word, store and return sum
  } op_e;

  // states of the command sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0, // waiting for a command
    SEQ_READ  = 2'd1, // memory read cycle
    SEQ_RESP  = 2'd2, // response push
    SEQ_WBACK = 2'd3  // accumulate write back
  } seq_state_e;

endpackage

`default_nettype wire
